//--- Bender.yml
package:
  name: mon_perf

sources:
  - files:
      - src/mon_pkg.sv
      - src/mon_ccu.sv
      - src/mon_counter_bank.sv
      - src/mon_ctrl.sv
      - src/mon_piso.sv
      - src/mon_top.sv
  - target: simulation
    files:
      - verification/mon_checker.sv
      - verification/tb_mon_top.sv

//--- project.f
src/mon_pkg.sv
src/mon_ccu.sv
src/mon_counter_bank.sv
src/mon_ctrl.sv
src/mon_piso.sv
src/mon_top.sv
verification/mon_checker.sv
verification/tb_mon_top.sv

//--- src/mon_ccu.sv
`timescale 1ns/1ps
// Config control unit
// Decodes instruction words into monitor start/abort pulses and counter clears
module mon_ccu (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        isa_vld,
    output logic                        isa_rdy,
    input  mon_pkg::isa_word_u          isa_word,
    input  logic                        cfg_rdy,
    output logic                        cfg_vld,
    output logic [mon_pkg::NUM_CNT-1:0] cnt_clr
);
    import mon_pkg::*;

    logic               isa_fire;
    logic               is_snap;
    logic               is_clear;
    logic               is_abort;
    // Pending snapshot and its clear_after flag
    logic               snap_pend_q;
    logic               snap_clr_q;
    logic               snap_issue;
    // Registered one-cycle commands
    logic               abort_q;
    logic [NUM_CNT-1:0] clr_q;

    //==========================================================================
    // Opcode decode
    //==========================================================================
    always_comb begin
        is_snap  = 1'b0;
        is_clear = 1'b0;
        is_abort = 1'b0;
        // Opcode sits in the same bits of both views
        case (isa_word.snap.opcode)
            OP_NOP: begin
                // Accepted and dropped
            end
            OP_SNAPSHOT: is_snap  = 1'b1;
            OP_CLEAR:    is_clear = 1'b1;
            OP_ABORT:    is_abort = 1'b1;
            default: begin
                // Unknown opcodes behave as NOP
            end
        endcase
    end

    // Only a second snapshot backs up while the monitor is busy
    assign isa_rdy  = !(snap_pend_q && !cfg_rdy && is_snap);
    assign isa_fire = isa_vld & isa_rdy;

    //==========================================================================
    // Command registers
    //==========================================================================
    // Pending snapshot goes out on the first idle cycle
    assign snap_issue = snap_pend_q & cfg_rdy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            snap_pend_q <= 1'b0;
            snap_clr_q  <= 1'b0;
            abort_q     <= 1'b0;
            clr_q       <= '0;
        end else begin
            // New snapshot may land in the same cycle the old one issues
            if (isa_fire && is_snap) begin
                snap_pend_q <= 1'b1;
                snap_clr_q  <= isa_word.snap.clear_after;
            end else if (snap_issue) begin
                snap_pend_q <= 1'b0;
            end
            abort_q <= isa_fire & is_abort;
            clr_q   <= (isa_fire && is_clear) ? isa_word.clr.clear_mask : '0;
        end
    end

    // Start when idle, abort only while offloading
    assign cfg_vld = snap_issue | (abort_q & !cfg_rdy);

    // CLEAR mask, or all counters on a clear_after capture
    assign cnt_clr = clr_q | {NUM_CNT{snap_issue & snap_clr_q}};

endmodule

//--- src/mon_counter_bank.sv
`timescale 1ns/1ps
// Bank of wrapping event counters with masked clear
module mon_counter_bank (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [mon_pkg::NUM_CNT-1:0] evt,
    input  logic [mon_pkg::NUM_CNT-1:0] cnt_clr,
    output mon_pkg::snap_t              snap
);
    import mon_pkg::*;

    // Element 0 in the low bits, same layout as the snapshot
    count_t [NUM_CNT-1:0] cnt_q;

    //==========================================================================
    // Counters
    //==========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else begin
            for (int i = 0; i < NUM_CNT; i++) begin
                // Clear wins, the event of this cycle is lost
                if (cnt_clr[i]) begin
                    cnt_q[i] <= '0;
                end else if (evt[i]) begin
                    // Wraps at 2^32
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
            end
        end
    end

    // Live counter values to the serializer
    assign snap = cnt_q;

endmodule

//--- src/mon_ctrl.sv
`timescale 1ns/1ps
// Monitor FSM with idle and offload states
module mon_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic cfg_vld,
    output logic cfg_rdy,
    input  logic done,
    output logic load,
    output logic flush
);
    import mon_pkg::*;

    logic state_q;
    logic state_d;

    //==========================================================================
    // Next state
    //==========================================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                // Start of a transfer
                if (cfg_vld) begin
                    state_d = ST_OFFLOAD;
                end
            end
            ST_OFFLOAD: begin
                // Abort, or last beat taken off-chip
                if (cfg_vld || done) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    //==========================================================================
    // Outputs
    //==========================================================================
    assign cfg_rdy = (state_q == ST_IDLE);

    // Capture in the start cycle itself
    assign load  = cfg_vld & (state_q == ST_IDLE);
    // cfg_vld while busy means abort
    assign flush = cfg_vld & (state_q == ST_OFFLOAD);

endmodule

//--- src/mon_piso.sv
`timescale 1ns/1ps
// Parallel-in serial-out stage, snapshot to 32-bit beats with last flag
// Flush drops the remaining beats
module mon_piso (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           load,
    input  logic           flush,
    input  mon_pkg::snap_t snap,
    output mon_pkg::beat_t itf_dat,
    output logic           itf_dat_vld,
    output logic           itf_dat_last,
    input  logic           itf_dat_rdy,
    output logic           done
);
    import mon_pkg::*;

    // Shift register, current beat in the low bits
    snap_t             sreg_q;
    logic              vld_q;
    logic [BCNT_W-1:0] bcnt_q;
    logic              beat_fire;

    assign beat_fire = vld_q & itf_dat_rdy;

    //==========================================================================
    // Control
    //==========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q  <= 1'b0;
            bcnt_q <= '0;
        end else if (flush) begin
            // Empty at once
            vld_q  <= 1'b0;
            bcnt_q <= '0;
        end else if (load) begin
            vld_q  <= 1'b1;
            bcnt_q <= '0;
        end else if (beat_fire) begin
            if (itf_dat_last) begin
                vld_q  <= 1'b0;
                bcnt_q <= '0;
            end else begin
                bcnt_q <= bcnt_q + 1'b1;
            end
        end
    end

    //==========================================================================
    // Payload
    //==========================================================================
    always_ff @(posedge clk) begin
        if (load) begin
            sreg_q <= snap;
        end else if (beat_fire) begin
            // Next counter down into the beat slot
            sreg_q <= sreg_q >> PORT_W;
        end
    end

    // Outputs hold while itf_dat_rdy is low
    assign itf_dat      = sreg_q[PORT_W-1:0];
    assign itf_dat_vld  = vld_q;
    // Beat counter rests at zero whenever no beat is valid
    assign itf_dat_last = (bcnt_q == BCNT_W'(BEAT_NUM - 1));

    // Last beat taken
    assign done = beat_fire & itf_dat_last;

endmodule

//--- src/mon_pkg.sv
// Performance monitor widths, opcodes, FSM state codes
// Counter, beat and snapshot types, and the instruction word union
package mon_pkg;

    //==========================================================================
    // Widths
    //==========================================================================
    // Three event counters of 32 bits each
    localparam int NUM_CNT  = 3;
    localparam int CNT_W    = 32;
    // Off-chip beat width
    localparam int PORT_W   = 32;
    // Whole snapshot, counter 0 in the low bits
    localparam int MON_W    = NUM_CNT * CNT_W;
    // Instruction word
    localparam int ISA_W    = 64;
    localparam int OP_W     = 4;
    // Beats per snapshot and beat counter width
    localparam int BEAT_NUM = MON_W / PORT_W;
    localparam int BCNT_W   = $clog2(BEAT_NUM);

    //==========================================================================
    // Opcodes, in bits 63:60 of every instruction
    //==========================================================================
    localparam logic [OP_W-1:0] OP_NOP      = 4'd0;
    localparam logic [OP_W-1:0] OP_SNAPSHOT = 4'd1;
    localparam logic [OP_W-1:0] OP_CLEAR    = 4'd2;
    localparam logic [OP_W-1:0] OP_ABORT    = 4'd3;

    // Monitor FSM states
    localparam logic ST_IDLE    = 1'b0;
    localparam logic ST_OFFLOAD = 1'b1;

    //==========================================================================
    // Types
    //==========================================================================
    typedef logic [CNT_W-1:0]  count_t;
    typedef logic [PORT_W-1:0] beat_t;
    typedef logic [MON_W-1:0]  snap_t;

    // SNAPSHOT view
    typedef struct packed {
        logic [OP_W-1:0]         opcode;
        // Zero all counters in the capture cycle
        logic                    clear_after;
        logic [ISA_W-OP_W-2:0]   rsvd;
    } isa_snap_t;

    // CLEAR view, one mask bit per counter
    typedef struct packed {
        logic [OP_W-1:0]               opcode;
        logic [NUM_CNT-1:0]            clear_mask;
        logic [ISA_W-OP_W-NUM_CNT-1:0] rsvd;
    } isa_clr_t;

    // Same 64-bit word, decoded by opcode
    typedef union packed {
        isa_snap_t snap;
        isa_clr_t  clr;
    } isa_word_u;

endpackage

//--- src/mon_top.sv
`timescale 1ns/1ps
// Performance monitor top: config unit, counter bank, monitor FSM, serializer
module mon_top (
    input  logic                        clk,
    input  logic                        rst_n,
    // Instruction port
    input  logic                        isa_vld,
    input  mon_pkg::isa_word_u          isa_word,
    output logic                        isa_rdy,
    // Event strobes from the accelerator
    input  logic [mon_pkg::NUM_CNT-1:0] evt,
    // Off-chip beat port
    output mon_pkg::beat_t              itf_dat,
    output logic                        itf_dat_vld,
    output logic                        itf_dat_last,
    input  logic                        itf_dat_rdy
);
    import mon_pkg::*;

    logic               cfg_vld;
    logic               cfg_rdy;
    logic [NUM_CNT-1:0] cnt_clr;
    snap_t              snap;
    logic               load;
    logic               flush;
    logic               done;

    //==========================================================================
    // Control
    //==========================================================================
    mon_ccu u_ccu (
        .clk      (clk),
        .rst_n    (rst_n),
        .isa_vld  (isa_vld),
        .isa_rdy  (isa_rdy),
        .isa_word (isa_word),
        .cfg_rdy  (cfg_rdy),
        .cfg_vld  (cfg_vld),
        .cnt_clr  (cnt_clr)
    );

    mon_ctrl u_ctrl (
        .clk     (clk),
        .rst_n   (rst_n),
        .cfg_vld (cfg_vld),
        .cfg_rdy (cfg_rdy),
        .done    (done),
        .load    (load),
        .flush   (flush)
    );

    //==========================================================================
    // Datapath
    //==========================================================================
    mon_counter_bank u_cnt (
        .clk     (clk),
        .rst_n   (rst_n),
        .evt     (evt),
        .cnt_clr (cnt_clr),
        .snap    (snap)
    );

    mon_piso u_piso (
        .clk          (clk),
        .rst_n        (rst_n),
        .load         (load),
        .flush        (flush),
        .snap         (snap),
        .itf_dat      (itf_dat),
        .itf_dat_vld  (itf_dat_vld),
        .itf_dat_last (itf_dat_last),
        .itf_dat_rdy  (itf_dat_rdy),
        .done         (done)
    );

endmodule

//--- verification/mon_checker.sv
`timescale 1ns/1ps
// Concurrent assertions on the beat handshake and instruction ready, bound into mon_top
module mon_checker (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           isa_rdy,
    input  logic           flush,
    input  mon_pkg::beat_t itf_dat,
    input  logic           itf_dat_vld,
    input  logic           itf_dat_last,
    input  logic           itf_dat_rdy
);

    // Failed assertions so far, read by the testbench
    int unsigned err_cnt = 0;

    //==========================================================================
    // Off-chip port
    //==========================================================================
    // Beat holds under back-pressure, unless an abort flushes it
    a_beat_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (itf_dat_vld && !itf_dat_rdy && !flush)
        |=> (itf_dat_vld && $stable(itf_dat) && $stable(itf_dat_last)))
    else begin
        $error("beat changed while stalled");
        err_cnt++;
    end

    // Last only on a valid beat
    a_last_vld: assert property (@(posedge clk) disable iff (!rst_n)
        itf_dat_last |-> itf_dat_vld)
    else begin
        $error("itf_dat_last high without itf_dat_vld");
        err_cnt++;
    end

    //==========================================================================
    // Instruction port
    //==========================================================================
    // Back-pressure only while a transfer runs
    a_isa_rdy: assert property (@(posedge clk) disable iff (!rst_n)
        !isa_rdy |-> itf_dat_vld)
    else begin
        $error("isa_rdy low with no transfer in progress");
        err_cnt++;
    end

endmodule

bind mon_top mon_checker u_chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .isa_rdy      (isa_rdy),
    .flush        (flush),
    .itf_dat      (itf_dat),
    .itf_dat_vld  (itf_dat_vld),
    .itf_dat_last (itf_dat_last),
    .itf_dat_rdy  (itf_dat_rdy)
);

//--- verification/tb_mon_top.sv
`timescale 1ns/1ps
// Testbench for mon_top: seeded random instructions, event strobes and stalls
// Cycle model of counters, pending snapshots and expected beats
module tb_mon_top;
    import mon_pkg::*;

    localparam int N_INSTR   = 400;
    localparam int RST_CYC   = 8;
    // Generous per-instruction budget, stalls included
    localparam int CYC_LIMIT = N_INSTR * 40 + RST_CYC;

    logic               clk;
    logic               rst_n;
    logic               isa_vld;
    isa_word_u          isa_word;
    logic               isa_rdy;
    logic [NUM_CNT-1:0] evt;
    beat_t              itf_dat;
    logic               itf_dat_vld;
    logic               itf_dat_last;
    logic               itf_dat_rdy;

    //==========================================================================
    // Reference model state
    //==========================================================================
    count_t             m_cnt [NUM_CNT];
    // Beats still expected, front is on the port now
    beat_t              exp_q [$];
    bit                 m_pend;
    bit                 m_pend_clr;
    bit                 m_abort;
    logic [NUM_CNT-1:0] m_clr;

    // Stimulus bookkeeping
    int                 instr_left;
    int                 gap_left;
    bit                 word_taken;
    int unsigned        cyc_cnt = 0;
    int unsigned        n_beats = 0;
    int unsigned        n_snaps = 0;
    int unsigned        n_aborts = 0;

    mon_top uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .isa_vld      (isa_vld),
        .isa_word     (isa_word),
        .isa_rdy      (isa_rdy),
        .evt          (evt),
        .itf_dat      (itf_dat),
        .itf_dat_vld  (itf_dat_vld),
        .itf_dat_last (itf_dat_last),
        .itf_dat_rdy  (itf_dat_rdy)
    );

    // 20 ns clock
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cyc_cnt++;
        if (cyc_cnt > CYC_LIMIT) begin
            stop_run($sformatf("Timeout: run did not finish within %0d cycles", CYC_LIMIT));
        end
    end

    //==========================================================================
    // Reporting and compare tasks
    //==========================================================================
    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_beat(input mon_pkg::beat_t got, input mon_pkg::beat_t exp);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] time %0t: itf_dat 0x%08h, expected 0x%08h",
                               $time, got, exp));
        end
    endtask

    task automatic check_last(input bit got, input bit exp);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] time %0t: itf_dat_last %0b, expected %0b",
                               $time, got, exp));
        end
    endtask

    task automatic check_idle(input bit got, input bit exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] time %0t: %s %0b, expected %0b", $time, what, got, exp));
        end
    endtask

    //==========================================================================
    // Stimulus
    //==========================================================================
    // Weighted opcode mix, random filler in the other bits
    function automatic isa_word_u make_instr();
        isa_word_u   w;
        int unsigned pick;
        w    = {$urandom, $urandom};
        pick = $urandom_range(0, 99);
        if (pick < 45) begin
            w.snap.opcode      = OP_SNAPSHOT;
            w.snap.clear_after = ($urandom_range(0, 3) == 0);
        end else if (pick < 65) begin
            w.clr.opcode     = OP_CLEAR;
            w.clr.clear_mask = NUM_CNT'($urandom_range(0, 7));
        end else if (pick < 82) begin
            w.snap.opcode = OP_ABORT;
        end else begin
            w.snap.opcode = OP_NOP;
        end
        return w;
    endfunction

    task automatic drive_inputs();
        evt         = NUM_CNT'($urandom_range(0, 7));
        // Output stalls roughly a third of the time
        itf_dat_rdy = ($urandom_range(0, 99) < 65);
        if (word_taken) begin
            isa_vld    = 1'b0;
            word_taken = 1'b0;
        end
        if (!isa_vld) begin
            if (gap_left > 0) begin
                gap_left--;
            end else if (instr_left > 0) begin
                isa_word = make_instr();
                isa_vld  = 1'b1;
            end
        end
    endtask

    //==========================================================================
    // Model step, mid-cycle
    //==========================================================================
    task automatic check_and_step();
        bit                 busy;
        bit                 exp_rdy;
        bit                 issue;
        bit                 abort_now;
        bit                 isa_fire;
        bit                 beat_fire;
        logic [OP_W-1:0]    op;
        logic [NUM_CNT-1:0] clr_now;

        busy = (exp_q.size() != 0);
        op   = isa_word.snap.opcode;
        if (uut.u_chk.err_cnt != 0) begin
            stop_run("Assertion failure reported by the checker");
        end
        // Only a further snapshot waits behind a pending one
        exp_rdy = !(m_pend && busy && op == OP_SNAPSHOT);
        check_idle(isa_rdy, exp_rdy, "isa_rdy");
        check_idle(itf_dat_vld, busy, "itf_dat_vld");
        if (busy) begin
            check_beat(itf_dat, exp_q[0]);
            check_last(itf_dat_last, exp_q.size() == 1);
        end else begin
            check_last(itf_dat_last, 1'b0);
        end

        // What happens at the coming edge
        issue     = m_pend && !busy;
        abort_now = m_abort && busy;
        isa_fire  = isa_vld && exp_rdy;
        beat_fire = busy && itf_dat_rdy;
        clr_now   = m_clr;
        if (issue && m_pend_clr) begin
            clr_now = '1;
        end

        // Capture takes this cycle's counts, before the clear
        if (issue) begin
            for (int i = 0; i < NUM_CNT; i++) begin
                exp_q.push_back(beat_t'(m_cnt[i]));
            end
            n_snaps++;
        end else if (abort_now) begin
            exp_q.delete();
            n_aborts++;
        end else if (beat_fire) begin
            void'(exp_q.pop_front());
            n_beats++;
        end

        // Clear wins over an event
        for (int i = 0; i < NUM_CNT; i++) begin
            if (clr_now[i]) begin
                m_cnt[i] = '0;
            end else if (evt[i]) begin
                m_cnt[i] = m_cnt[i] + 1'b1;
            end
        end

        if (isa_fire && op == OP_SNAPSHOT) begin
            m_pend     = 1'b1;
            m_pend_clr = isa_word.snap.clear_after;
        end else if (issue) begin
            m_pend = 1'b0;
        end
        m_abort = isa_fire && op == OP_ABORT;
        m_clr   = (isa_fire && op == OP_CLEAR) ? isa_word.clr.clear_mask : '0;

        if (isa_fire) begin
            word_taken = 1'b1;
            instr_left--;
            gap_left   = ($urandom_range(0, 1) == 0) ? 0 : $urandom_range(1, 4);
        end
    endtask

    //==========================================================================
    // Main sequence
    //==========================================================================
    initial begin
        void'($urandom(41));
        clk         = 1'b0;
        rst_n       = 1'b0;
        isa_vld     = 1'b0;
        isa_word    = '0;
        evt         = '0;
        itf_dat_rdy = 1'b0;
        for (int i = 0; i < NUM_CNT; i++) begin
            m_cnt[i] = '0;
        end
        m_pend     = 1'b0;
        m_pend_clr = 1'b0;
        m_abort    = 1'b0;
        m_clr      = '0;
        instr_left = N_INSTR;
        gap_left   = 0;
        word_taken = 1'b0;

        repeat (RST_CYC) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        check_idle(itf_dat_vld, 1'b0, "itf_dat_vld after reset");
        check_idle(isa_rdy, 1'b1, "isa_rdy after reset");

        // Until every word is taken and the last transfer drains
        while (instr_left > 0 || isa_vld || m_pend || exp_q.size() != 0) begin
            @(posedge clk);
            #2;
            drive_inputs();
            @(negedge clk);
            check_and_step();
        end

        $display("Snapshots %0d, aborts %0d, beats %0d", n_snaps, n_aborts, n_beats);
        if (uut.u_chk.err_cnt == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            stop_run("Assertion failure reported by the checker");
        end
    end

endmodule
